/* sim.f */
+incdir+logic
logic/fpm_pkg.sv
logic/fpm_pipe_delay.sv
logic/fpm_classify.sv
logic/fpm_mant_path.sv
logic/fpm_pack.sv
logic/fpm_req_ctrl.sv
logic/fpm_unit.sv
tb/fpm_clk_gen.sv
tb/fpm_checker.sv
tb/fpm_properties.sv
tb/fpm_tb.sv

/* Makefile */
SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := fpm_tb
FILELIST := sim.f
OBJ_DIR  := obj_dir
SIM_BIN  := $(OBJ_DIR)/V$(TOP)
RUN_ARGS := +verilator+error+limit+100
PASS_MSG := Finished with no errors

SOURCES := $(shell grep -v '^+' $(FILELIST)) logic/fpm_params.svh

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN) $(RUN_ARGS))"; echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* tb/fpm_tb.sv */
`timescale 1ns/1ps

`include "fpm_params.svh"

module fpm_tb;

  localparam int NUM_ROWS     = 15;
  localparam int PERIOD       = 20;
  localparam int RESET_CYCLES = 8;

  typedef struct packed {
    logic [127:0]   name;
    fpm_pkg::fp32_t a;
    fpm_pkg::fp32_t b;
    fpm_pkg::fp32_t z;
  } row_t;

  logic           clk;
  logic           rst_n;
  logic           req;
  logic           ack;
  fpm_pkg::fp32_t a;
  fpm_pkg::fp32_t b;
  fpm_pkg::fp32_t z;
  fpm_pkg::fp32_t exp_z;
  logic [127:0]   test_name;
  int             err_count;
  int             seed;
  row_t           rows [NUM_ROWS];

  fpm_clk_gen #(.PERIOD(PERIOD), .RESET_CYCLES(RESET_CYCLES)) clk_gen_i (
    .clk   (clk),
    .rst_n (rst_n)
  );

  fpm_unit dut_i (
    .clk   (clk),
    .rst_n (rst_n),
    .req   (req),
    .a     (a),
    .b     (b),
    .ack   (ack),
    .z     (z)
  );

  fpm_checker checker_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .req       (req),
    .ack       (ack),
    .z         (z),
    .exp_z     (exp_z),
    .test_name (test_name),
    .err_count (err_count)
  );

  bind fpm_unit fpm_properties props_i (
    .clk   (clk),
    .rst_n (rst_n),
    .req   (req),
    .ack   (ack),
    .z     (z)
  );

  // ============================================================
  // stimulus table, expected words worked out by hand
  // ============================================================
  initial begin
    rows[0]  = '{"mul_1p5_x2",   32'h3FC0_0000, 32'h4000_0000, 32'h4040_0000};
    rows[1]  = '{"mul_3_x_m0p5", 32'h4040_0000, 32'hBF00_0000, 32'hBFC0_0000};
    rows[2]  = '{"norm_1p5_sq",  32'h3FC0_0000, 32'h3FC0_0000, 32'h4010_0000};
    rows[3]  = '{"trunc_ulp",    32'h3FC0_0000, 32'h3F80_0001, 32'h3FC0_0001};
    rows[4]  = '{"m1_x_m1",      32'hBF80_0000, 32'hBF80_0000, 32'h3F80_0000};
    rows[5]  = '{"nan_a",        32'h7F80_0001, 32'h3F80_0000, `FPM_QNAN};
    rows[6]  = '{"nan_b",        32'h3F80_0000, 32'hFFC0_0000, `FPM_QNAN};
    rows[7]  = '{"inf_x_zero",   32'h7F80_0000, 32'h0000_0000, `FPM_QNAN};
    rows[8]  = '{"inf_x_m2",     32'h7F80_0000, 32'hC000_0000, 32'hFF80_0000};
    rows[9]  = '{"mzero_x_5",    32'h8000_0000, 32'h40A0_0000, 32'h0000_0000};
    rows[10] = '{"m3_x_zero",    32'hC040_0000, 32'h0000_0000, 32'h0000_0000};
    rows[11] = '{"ovf_neg",      32'h7F00_0000, 32'hC000_0000, 32'hFF80_0000};
    rows[12] = '{"ovf_max",      32'h7F7F_FFFF, 32'h7F7F_FFFF, 32'h7F80_0000};
    rows[13] = '{"unf_tiny",     32'h0080_0000, 32'h3F00_0000, 32'h0000_0000};
    rows[14] = '{"subnorm_x1",   32'h0040_0000, 32'h3F80_0000, 32'h0000_0000};
  end

  // full four-phase cycle with a random hold after ack
  task automatic run_row(input row_t row);
    int extra;
    req       <= 1'b1;
    a         <= row.a;
    b         <= row.b;
    exp_z     <= row.z;
    test_name <= row.name;
    do @(posedge clk); while (!ack);
    extra = $unsigned($random(seed)) % 6;
    repeat (extra) @(posedge clk);
    req <= 1'b0;
    do @(posedge clk); while (ack);
  endtask

  initial begin
    seed      = 84;
    req       = 1'b0;
    a         = '0;
    b         = '0;
    exp_z     = '0;
    test_name = '0;
    wait (rst_n === 1'b1);
    @(posedge clk);
    for (int i = 0; i < NUM_ROWS; i++) begin
      run_row(rows[i]);
    end
    repeat (2) @(posedge clk);
    $display("rows run: %0d, errors: %0d", NUM_ROWS, err_count);
    if (err_count == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  // watchdog, 20 cycles per row plus reset
  initial begin
    #((NUM_ROWS * 20 + RESET_CYCLES) * PERIOD);
    $display("timeout: the handshake did not complete in time");
    $display("rows run: incomplete, errors: %0d", err_count);
    $display("Finished with errors");
    $finish;
  end

endmodule

/* tb/fpm_properties.sv */
`timescale 1ns/1ps

`include "fpm_params.svh"

module fpm_properties (
  input logic           clk,
  input logic           rst_n,
  input logic           req,
  input logic           ack,
  input fpm_pkg::fp32_t z
);

  // one extra sample since both edges are seen through sampled values
  localparam int ACK_DELAY = `FPM_CORE_STAGES + 1;

  ack_latency_a: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(req) |-> ##ACK_DELAY $rose(ack))
    else $error("ack did not rise %0d cycles after req", `FPM_CORE_STAGES);

  z_hold_a: assert property (@(posedge clk) disable iff (!rst_n)
    (ack && $past(ack)) |-> $stable(z))
    else $error("z changed while ack was high");

  ack_drop_a: assert property (@(posedge clk) disable iff (!rst_n)
    (ack && !req) |=> !ack)
    else $error("ack did not fall one cycle after req dropped");

endmodule

/* tb/fpm_checker.sv */
`timescale 1ns/1ps

`include "fpm_params.svh"

module fpm_checker (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           req,
  input  logic           ack,
  input  fpm_pkg::fp32_t z,
  input  fpm_pkg::fp32_t exp_z,
  input  logic [127:0]   test_name,
  output int             err_count
);

  logic           rst_q   = 1'b1;
  logic           req_q   = 1'b0;
  logic           ack_q   = 1'b0;
  fpm_pkg::fp32_t z_q     = '0;
  int             lat_cnt = 0;
  int             errors  = 0;

  assign err_count = errors;

  always @(posedge clk) begin
    rst_q <= rst_n;
    req_q <= req;
    ack_q <= ack;
    z_q   <= z;
    // values left by a reset edge
    if (!rst_q && (ack !== 1'b0 || z !== 32'd0)) begin
      $display("reset did not clear the outputs, ack=%b z=%h", ack, z);
      errors++;
    end
    if (rst_n && rst_q) begin
      lat_cnt <= (req && !req_q && !ack) ? 0 : lat_cnt + 1;
      if (ack && !ack_q) begin
        if (!req_q) begin
          $display("ack rose while no request was pending");
          errors++;
        end else if (lat_cnt != `FPM_CORE_STAGES) begin
          $display("ack rose %0d cycles after req, not %0d", lat_cnt, `FPM_CORE_STAGES);
          errors++;
        end
        if (z !== exp_z) begin
          $display("FAIL %s: expected %h, actual %h", test_name, exp_z, z);
          errors++;
        end
      end
      if (ack && ack_q && z !== z_q) begin
        $display("z changed from %h to %h while ack was high", z_q, z);
        errors++;
      end
      if (ack && !req && !req_q) begin
        $display("ack still high one cycle after req dropped");
        errors++;
      end
    end
  end

endmodule

/* tb/fpm_clk_gen.sv */
`timescale 1ns/1ps

module fpm_clk_gen #(
  parameter int PERIOD       = 20,
  parameter int RESET_CYCLES = 8
) (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  // reset released on a rising edge
  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
  end

endmodule

/* logic/fpm_unit.sv */
`timescale 1ns/1ps

`include "fpm_params.svh"

module fpm_unit (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           req,
  input  fpm_pkg::fp32_t a,
  input  fpm_pkg::fp32_t b,
  output logic           ack,
  output fpm_pkg::fp32_t z
);

  logic              issue;
  logic              done_core;
  fpm_pkg::special_t special_s1;
  fpm_pkg::special_t special_s2;
  fpm_pkg::mant_t    mant_s2;
  fpm_pkg::fp32_t    z_core;

  fpm_req_ctrl ctrl_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .req       (req),
    .issue     (issue),
    .done_core (done_core),
    .z_core    (z_core),
    .ack       (ack),
    .z         (z)
  );

  // ============================================================
  // core datapath, both paths see the port operands
  // ============================================================
  fpm_classify classify_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .a       (a),
    .b       (b),
    .special (special_s1)
  );

  fpm_mant_path mant_i (
    .clk   (clk),
    .rst_n (rst_n),
    .a     (a),
    .b     (b),
    .mant  (mant_s2)
  );

  // line up the special result with stage two of the mantissa path
  fpm_pipe_delay #(
    .payload_t (fpm_pkg::special_t),
    .DEPTH     (1)
  ) special_dly_i (
    .clk   (clk),
    .rst_n (rst_n),
    .d     (special_s1),
    .q     (special_s2)
  );

  fpm_pack pack_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .special (special_s2),
    .mant    (mant_s2),
    .z_core  (z_core)
  );

  // per-stage valid bits
  fpm_pipe_delay #(
    .payload_t (logic),
    .DEPTH     (`FPM_CORE_STAGES)
  ) valid_dly_i (
    .clk   (clk),
    .rst_n (rst_n),
    .d     (issue),
    .q     (done_core)
  );

endmodule

/* logic/fpm_req_ctrl.sv */
`timescale 1ns/1ps

module fpm_req_ctrl (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           req,
  output logic           issue,
  input  logic           done_core,
  input  fpm_pkg::fp32_t z_core,
  output logic           ack,
  output fpm_pkg::fp32_t z
);

  typedef enum logic [1:0] {
    st_idle,
    st_busy,
    st_ack
  } state_t;

  state_t state;

  // core starts on the edge that samples req
  assign issue = (state == st_idle) && req;
  assign ack   = (state == st_ack);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= st_idle;
      z     <= '0;
    end else begin
      case (state)
        st_idle: begin
          if (req) state <= st_busy;
        end
        st_busy: begin
          if (done_core) begin
            state <= st_ack;
            z     <= z_core;
          end
        end
        // hold result until the requester lets go
        st_ack: begin
          if (!req) state <= st_idle;
        end
        default: state <= st_idle;
      endcase
    end
  end

endmodule

/* logic/fpm_pack.sv */
`timescale 1ns/1ps

`include "fpm_params.svh"

module fpm_pack (
  input  logic              clk,
  input  logic              rst_n,
  input  fpm_pkg::special_t special,
  input  fpm_pkg::mant_t    mant,
  output fpm_pkg::fp32_t    z_core
);

  localparam logic signed [10:0] BIAS11 = 11'(`FPM_BIAS);

  logic signed [10:0] exp_ext;
  logic signed [10:0] norm_exp;
  logic [22:0]        frac;
  fpm_pkg::fp32_t     z_nxt;

  // sign-extend the unbiased sum before rebiasing
  assign exp_ext = $signed({mant.exp_sum[9], mant.exp_sum});

  // one-place normalize when the product is in [2,4)
  assign norm_exp = exp_ext + BIAS11 + $signed({10'd0, mant.prod[47]});
  assign frac     = mant.prod[47] ? mant.prod[46:24] : mant.prod[45:23];

  // ============================================================
  // result select
  // ============================================================
  always_comb begin
    if (special.hit) begin
      z_nxt = special.word;
    end else if (norm_exp >= 11'sd255) begin
      // overflow, signed infinity
      z_nxt = {mant.sign, 8'hFF, 23'd0};
    end else if (norm_exp <= 11'sd0) begin
      // underflow flushes to +0
      z_nxt = '0;
    end else begin
      z_nxt = {mant.sign, norm_exp[7:0], frac};
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      z_core <= '0;
    end else begin
      z_core <= z_nxt;
    end
  end

endmodule

/* logic/fpm_mant_path.sv */
`timescale 1ns/1ps

`include "fpm_params.svh"

module fpm_mant_path (
  input  logic           clk,
  input  logic           rst_n,
  input  fpm_pkg::fp32_t a,
  input  fpm_pkg::fp32_t b,
  output fpm_pkg::mant_t mant
);

  localparam logic signed [9:0] BIAS10 = 10'(`FPM_BIAS);

  logic signed [9:0] exp_a;
  logic signed [9:0] exp_b;
  logic [23:0]       sig_a;
  logic [23:0]       sig_b;

  logic              s1_sign;
  logic signed [9:0] s1_exp;
  logic [23:0]       s1_sig_a;
  logic [23:0]       s1_sig_b;

  // a zero exponent field stays at raw value 0 when unbiased
  assign exp_a = $signed({2'b00, a[30:23]}) - BIAS10;
  assign exp_b = $signed({2'b00, b[30:23]}) - BIAS10;

  // hidden bit dropped for subnormals
  assign sig_a = {(a[30:23] != 8'd0), a[22:0]};
  assign sig_b = {(b[30:23] != 8'd0), b[22:0]};

  // ============================================================
  // stage one registers sign, exponent sum and significands
  // ============================================================
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      s1_sign  <= 1'b0;
      s1_exp   <= '0;
      s1_sig_a <= '0;
      s1_sig_b <= '0;
    end else begin
      s1_sign  <= a[31] ^ b[31];
      s1_exp   <= exp_a + exp_b;
      s1_sig_a <= sig_a;
      s1_sig_b <= sig_b;
    end
  end

  // stage two forms the full 48-bit product
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      mant <= '0;
    end else begin
      mant.sign    <= s1_sign;
      mant.exp_sum <= s1_exp;
      mant.prod    <= 48'(s1_sig_a) * 48'(s1_sig_b);
    end
  end

endmodule

/* logic/fpm_classify.sv */
`timescale 1ns/1ps

`include "fpm_params.svh"

module fpm_classify (
  input  logic              clk,
  input  logic              rst_n,
  input  fpm_pkg::fp32_t    a,
  input  fpm_pkg::fp32_t    b,
  output fpm_pkg::special_t special
);

  logic              a_nan;
  logic              b_nan;
  logic              a_inf;
  logic              b_inf;
  logic              a_zero;
  logic              b_zero;
  logic              res_sign;
  fpm_pkg::special_t special_nxt;

  // operand decode
  assign a_nan    = (a[30:23] == 8'hFF) && (a[22:0] != 23'd0);
  assign b_nan    = (b[30:23] == 8'hFF) && (b[22:0] != 23'd0);
  assign a_inf    = (a[30:23] == 8'hFF) && (a[22:0] == 23'd0);
  assign b_inf    = (b[30:23] == 8'hFF) && (b[22:0] == 23'd0);
  assign a_zero   = (a[30:0] == 31'd0);
  assign b_zero   = (b[30:0] == 31'd0);
  assign res_sign = a[31] ^ b[31];

  // nan first, then infinity, then zero
  always_comb begin
    special_nxt = '0;
    if (a_nan || b_nan || (a_inf && b_zero) || (a_zero && b_inf)) begin
      special_nxt.hit  = 1'b1;
      special_nxt.word = `FPM_QNAN;
    end else if (a_inf || b_inf) begin
      special_nxt.hit  = 1'b1;
      special_nxt.word = {res_sign, 8'hFF, 23'd0};
    end else if (a_zero || b_zero) begin
      // zero product is always +0
      special_nxt.hit  = 1'b1;
      special_nxt.word = '0;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      special <= '0;
    end else begin
      special <= special_nxt;
    end
  end

endmodule

/* logic/fpm_pipe_delay.sv */
`timescale 1ns/1ps

module fpm_pipe_delay #(
  parameter type    payload_t = logic,
  parameter integer DEPTH     = 1
) (
  input  logic     clk,
  input  logic     rst_n,
  input  payload_t d,
  output payload_t q
);

  payload_t chain [DEPTH];

  // shift chain, oldest entry at the far end
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < DEPTH; i++) begin
        chain[i] <= '0;
      end
    end else begin
      chain[0] <= d;
      for (int i = 1; i < DEPTH; i++) begin
        chain[i] <= chain[i-1];
      end
    end
  end

  assign q = chain[DEPTH-1];

endmodule

/* logic/fpm_pkg.sv */
package fpm_pkg;

  // ============================================================
  // shared types for the fp32 multiply unit
  // ============================================================

  // raw ieee-754 single precision word
  typedef logic [31:0] fp32_t;

  // forced result from the special-case decode
  typedef struct packed {
    logic  hit;
    fp32_t word;
  } special_t;

  // sign, unbiased exponent sum and raw 24x24 significand product
  typedef struct packed {
    logic              sign;
    logic signed [9:0] exp_sum;
    logic [47:0]       prod;
  } mant_t;

endpackage

/* logic/fpm_params.svh */
`ifndef FPM_PARAMS_SVH
`define FPM_PARAMS_SVH

// ============================================================
// numeric constants for the fp32 multiplier
// ============================================================

// ieee-754 single precision exponent bias
`define FPM_BIAS 127

// canonical quiet nan, sign bit clear
`define FPM_QNAN 32'h7FC0_0000

// cycles from issue to a registered core result
`define FPM_CORE_STAGES 3

`endif
